// ==== filelist.f ====
logic/joypad_pkg.sv
logic/pin_sync.sv
logic/bus_bridge.sv
logic/joypad_io.sv
logic/joypad_irq.sv
logic/joypad_top.sv
verification/joypad_chk.sv
verification/joypad_checker.sv
verification/joypad_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = joypad_tb
FILELIST = filelist.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -qF "*** PASSED ***" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== verification/joypad_tb.sv ====
`timescale 1ns/1ps

module keypad_model (
	input  logic [7:0] buttons,
	input  logic       p14,
	input  logic       p15,
	output logic [3:0] lines
);
	// a pressed key shorts its line to a low select line
	assign lines = ~((buttons[3:0] & {4{~p14}}) | (buttons[7:4] & {4{~p15}}));
endmodule

module joypad_tb;
	import joypad_pkg::*;

	localparam int SYNC    = 2;
	localparam int TIMEOUT = 40;

	logic        clk;
	logic        arst_n;
	logic        req;
	logic        we;
	joy_data_t   wdata;
	logic        ack;
	joy_data_t   rdata;
	logic [3:0]  lines;
	logic        p14;
	logic        p15;
	logic        irq;
	logic        irq_ack;
	logic [7:0]  buttons;
	logic [31:0] lcg_state;
	string       test_name;
	int          chk_count;
	int          chk_errors;
	int          tb_checks;
	int          tb_fails;
	int          test_count;
	int          errors_at_start;

	joypad_top #(.SYNC_STAGES(SYNC)) UUT (
		.clk(clk), .arst_n(arst_n), .req(req), .we(we), .wdata(wdata), .ack(ack),
		.rdata(rdata), .p10(lines[0]), .p11(lines[1]), .p12(lines[2]), .p13(lines[3]),
		.p14(p14), .p15(p15), .irq(irq), .irq_ack(irq_ack)
	);

	keypad_model u_keypad (.buttons(buttons), .p14(p14), .p15(p15), .lines(lines));

	joypad_checker u_checker (
		.clk(clk), .arst_n(arst_n), .we(we), .wdata(wdata), .ack(ack), .rdata(rdata),
		.p14(p14), .p15(p15), .irq(irq), .irq_ack(irq_ack), .buttons(buttons),
		.test_name(test_name), .check_count(chk_count), .err_count(chk_errors)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic wait_ack(input logic level);
		int n;
		n = 0;
		while (ack !== level && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		if (ack !== level) begin
			tb_fails++;
			$display("%s: ack did not go to %0d within %0d cycles", test_name, level, TIMEOUT);
		end
	endtask

	task automatic wait_irq(input logic level, input string what);
		int n;
		n = 0;
		while (irq !== level && n < TIMEOUT) begin
			@(posedge clk);
			#1;
			n++;
		end
		tb_checks++;
		if (irq !== level) begin
			tb_fails++;
			$display("%s: %s", test_name, what);
		end
	endtask

	// irq must keep its level for the whole window
	task automatic hold_irq(input logic level, input int cycles, input string what);
		bit bad;
		bad = 1'b0;
		for (int n = 0; n < cycles; n++) begin
			@(posedge clk);
			#1;
			if (irq !== level && !bad) begin
				bad = 1'b1;
				tb_fails++;
				$display("ERR %s %s: expected %b actual %b", test_name, what, level, irq);
			end
		end
		tb_checks++;
	endtask

	task automatic bus_access(input logic write, input joy_data_t data);
		@(posedge clk);
		#1;
		we    = write;
		wdata = data;
		req   = 1'b1;
		wait_ack(1'b1);
		req = 1'b0;
		wait_ack(1'b0);
	endtask

	task automatic settle;
		repeat (SYNC + 1) @(posedge clk);
		#1;
	endtask

	task automatic service_irq;
		@(posedge clk);
		#1;
		irq_ack = 1'b1;
		wait_irq(1'b0, "irq did not drop after irq_ack");
		irq_ack = 1'b0;
	endtask

	// clears requests left over from earlier key presses
	task automatic drain_irq;
		int n;
		n = 0;
		settle();
		while (irq && n < 8) begin
			service_irq();
			repeat (2) @(posedge clk);
			#1;
			n++;
		end
		hold_irq(1'b0, 1, "irq stuck high after servicing");
	endtask

	task automatic start_test(input string name);
		test_name       = name;
		errors_at_start = chk_errors + tb_fails;
	endtask

	task automatic end_test;
		int errs;
		errs = chk_errors + tb_fails - errors_at_start;
		test_count++;
		if (errs == 0) $display("test %s: ok", test_name);
		else $display("test %s: %0d errors", test_name, errs);
	endtask

	initial begin
		#1000000;
		$display("simulation stopped by the watchdog");
		$display("*** FAILED ***");
		$finish;
	end

	initial begin
		joy_data_t rnd;
		int        total_errs;
		arst_n = 1'b0;
		req = 1'b0;
		we = 1'b0;
		wdata = '0;
		irq_ack = 1'b0;
		buttons = '0;
		lcg_state = 32'd24258;
		tb_checks = 0;
		tb_fails = 0;
		test_count = 0;
		errors_at_start = 0;
		test_name = "reset";
		repeat (5) @(posedge clk);
		#1;
		arst_n = 1'b1;

		start_test("reset");
		bus_access(1'b0, '0);
		end_test();

		start_test("select");
		for (int s = 0; s < 4; s++) begin
			lcg_state = lcg_next(lcg_state);
			rnd = lcg_state[23:16];
			bus_access(1'b1, {rnd[7:6], s[1:0], rnd[3:0]}); // junk outside 5:4
			settle();
			bus_access(1'b0, '0);
		end
		end_test();

		start_test("pad matrix");
		for (int s = 0; s < 4; s++) begin
			bus_access(1'b1, {2'b00, s[1:0], 4'h0});
			for (int k = 0; k < 50; k++) begin
				lcg_state = lcg_next(lcg_state);
				buttons = lcg_state[23:16];
				settle();
				bus_access(1'b0, '0);
			end
		end
		buttons = '0;
		bus_access(1'b1, 8'h30);
		drain_irq();
		end_test();

		start_test("irq");
		bus_access(1'b1, 8'h20); // p14 low, direction keys
		settle();
		buttons = 8'h01;
		wait_irq(1'b1, "irq did not rise after a key press");
		hold_irq(1'b1, 4, "irq dropped before irq_ack");
		service_irq();
		buttons = '0;
		drain_irq();
		bus_access(1'b1, 8'h30); // no group selected
		settle();
		buttons = 8'h0F;
		hold_irq(1'b0, SYNC + 6, "irq raised with no group selected");
		buttons = '0;
		end_test();

		start_test("irq merge");
		bus_access(1'b1, 8'h20);
		settle();
		buttons = 8'h01;
		wait_irq(1'b1, "irq did not rise after the first key");
		@(posedge clk);
		#1;
		irq_ack = 1'b1;
		wait_irq(1'b0, "irq did not drop after irq_ack");
		buttons = 8'h03; // second key lands while irq_ack is held
		hold_irq(1'b0, SYNC + 6, "irq rose while irq_ack was high");
		irq_ack = 1'b0;
		wait_irq(1'b1, "merged key press did not raise irq again");
		service_irq();
		buttons = '0;
		drain_irq();
		end_test();

		total_errs = chk_errors + tb_fails + UUT.u_joypad_chk.fail_count;
		$display("%0d tests, %0d checks, %0d errors", test_count, chk_count + tb_checks,
			total_errs);
		if (total_errs == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// ==== verification/joypad_checker.sv ====
`timescale 1ns/1ps

module joypad_checker (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  we,
	input  joypad_pkg::joy_data_t wdata,
	input  logic                  ack,
	input  joypad_pkg::joy_data_t rdata,
	input  logic                  p14,
	input  logic                  p15,
	input  logic                  irq,
	input  logic                  irq_ack,
	input  logic [7:0]            buttons,
	input  string                 test_name,
	output int                    check_count,
	output int                    err_count
);
	import joypad_pkg::*;

	logic [1:0] sel_exp;
	logic       ack_prev;
	logic       reset_checked;

	// buttons[3:0] are the direction keys, buttons[7:4] the action buttons
	function automatic joy_data_t expected_ff00(input logic [1:0] sel, input logic [7:0] btn);
		logic [JOY_LINES-1:0] lines;
		for (int i = 0; i < JOY_LINES; i++) begin
			lines[i] = !((btn[i] && !sel[0]) || (btn[i+4] && !sel[1])); // pressed and selected
		end
		return {UNUSED_HIGH, sel, lines};
	endfunction

	task automatic check_value(input string what, input joy_data_t exp, input joy_data_t act);
		check_count++;
		if (act !== exp) begin
			err_count++;
			$display("ERR %s %s: expected %h actual %h", test_name, what, exp, act);
		end
	endtask

	// sample mid cycle, away from the driving edge
	always @(negedge clk) begin
		if (!arst_n) begin
			sel_exp       = SEL_RESET;
			ack_prev      = 1'b0;
			reset_checked = 1'b0;
			check_count   = 0;
			err_count     = 0;
		end else begin
			if (!reset_checked) begin
				check_value("reset levels", 8'b0000_0011, {3'b0, ack, irq, irq_ack, p15, p14});
				reset_checked = 1'b1;
			end
			if (ack && !ack_prev) begin
				if (we) begin
					sel_exp = wdata[SEL_LSB +: 2]; // only the select field is kept
					check_value("select pins", {6'b0, sel_exp}, {6'b0, p15, p14});
				end else begin
					check_value("read data", expected_ff00(sel_exp, buttons), rdata);
				end
			end
			ack_prev = ack;
		end
	end

endmodule

// ==== verification/joypad_chk.sv ====
`timescale 1ns/1ps

module joypad_chk (
	input logic clk,
	input logic arst_n,
	input logic req,
	input logic ack,
	input logic irq,
	input logic irq_ack
);
	int fail_count = 0;

	ack_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(ack) |-> $past(req)) // ack only answers a live request
	else begin
		fail_count++;
		$error("ack rose without a pending req");
	end

	ack_low_in_reset: assert property (@(posedge clk) !arst_n |-> !ack)
	else begin
		fail_count++;
		$error("ack high while reset is asserted");
	end

	irq_waits_release: assert property (@(posedge clk) disable iff (!arst_n)
		$rose(irq) |-> !$past(irq_ack)) // next request only after irq_ack drops
	else begin
		fail_count++;
		$error("irq rose again while irq_ack was still high");
	end

endmodule

bind joypad_top joypad_chk u_joypad_chk (
	.clk    (clk),
	.arst_n (arst_n),
	.req    (req),
	.ack    (ack),
	.irq    (irq),
	.irq_ack(irq_ack)
);

// ==== logic/joypad_top.sv ====
`timescale 1ns/1ps

module joypad_top #(
	parameter int SYNC_STAGES = 2
) (
	input  logic                  clk,
	input  logic                  arst_n,

	input  logic                  req,
	input  logic                  we,
	input  joypad_pkg::joy_data_t wdata,
	output logic                  ack,
	output joypad_pkg::joy_data_t rdata,

	input  logic                  p10,
	input  logic                  p11,
	input  logic                  p12,
	input  logic                  p13,
	output logic                  p14,
	output logic                  p15,

	output logic                  irq,
	input  logic                  irq_ack
);
	import joypad_pkg::*;

	logic [JOY_LINES-1:0] pad_async;
	logic [JOY_LINES-1:0] pad_sync;
	logic                 wr_stb;
	logic                 rd_stb;
	joy_data_t            reg_wdata;
	joy_data_t            reg_rdata;

	assign pad_async = {p13, p12, p11, p10}; // bit order of FF00[3:0]

	pin_sync #(
		.SYNC_STAGES(SYNC_STAGES)
	) u_pin_sync (
		.clk     (clk),
		.arst_n  (arst_n),
		.async_in(pad_async),
		.sync_out(pad_sync)
	);

	bus_bridge u_bus_bridge (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      (req),
		.we       (we),
		.wdata    (wdata),
		.ack      (ack),
		.rdata    (rdata),
		.wr_stb   (wr_stb),
		.rd_stb   (rd_stb),
		.reg_wdata(reg_wdata),
		.reg_rdata(reg_rdata)
	);

	joypad_io u_joypad_io (
		.clk     (clk),
		.arst_n  (arst_n),
		.wr_stb  (wr_stb),
		.rd_stb  (rd_stb),
		.wdata   (reg_wdata),
		.pad_sync(pad_sync),
		.rdata   (reg_rdata),
		.p14     (p14),
		.p15     (p15)
	);

	joypad_irq u_joypad_irq (
		.clk     (clk),
		.arst_n  (arst_n),
		.pad_sync(pad_sync),
		.irq     (irq),
		.irq_ack (irq_ack)
	);

endmodule

// ==== logic/joypad_irq.sv ====
`timescale 1ns/1ps

module joypad_irq (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [joypad_pkg::JOY_LINES-1:0] pad_sync,
	output logic                            irq,
	input  logic                            irq_ack
);
	import joypad_pkg::*;

	typedef enum logic [1:0] {
		IRQ_IDLE,
		IRQ_WAIT_ACK,
		IRQ_WAIT_REL
	} irq_state_t;

	irq_state_t           state_q;
	logic [JOY_LINES-1:0] pad_prev_q;
	logic [JOY_LINES-1:0] fall;
	logic                 any_fall;
	logic                 pending_q;

	assign fall     = pad_prev_q & ~pad_sync; // 1 -> 0 on any line
	assign any_fall = |fall;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pad_prev_q <= PAD_IDLE;
			state_q    <= IRQ_IDLE;
			irq        <= 1'b0;
			pending_q  <= 1'b0;
		end else begin
			pad_prev_q <= pad_sync;
			case (state_q)
				IRQ_IDLE: begin
					if (any_fall) begin
						irq     <= 1'b1;
						state_q <= IRQ_WAIT_ACK;
					end
				end
				IRQ_WAIT_ACK: begin
					pending_q <= pending_q | any_fall; // merge while busy
					if (irq_ack) begin
						irq     <= 1'b0;
						state_q <= IRQ_WAIT_REL;
					end
				end
				IRQ_WAIT_REL: begin
					if (!irq_ack) begin
						pending_q <= 1'b0;
						if (pending_q || any_fall) begin
							irq     <= 1'b1; // replay merged edges
							state_q <= IRQ_WAIT_ACK;
						end else begin
							state_q <= IRQ_IDLE;
						end
					end else begin
						pending_q <= pending_q | any_fall;
					end
				end
				default: begin
					irq     <= 1'b0;
					state_q <= IRQ_IDLE;
				end
			endcase
		end
	end

endmodule

// ==== logic/joypad_io.sv ====
`timescale 1ns/1ps

module joypad_io (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic                            wr_stb,
	input  logic                            rd_stb,
	input  joypad_pkg::joy_data_t           wdata,
	input  logic [joypad_pkg::JOY_LINES-1:0] pad_sync,
	output joypad_pkg::joy_data_t           rdata,
	output logic                            p14,
	output logic                            p15
);
	import joypad_pkg::*;

	logic [SEL_WIDTH-1:0] sel_q;
	logic [SEL_WIDTH-1:0] sel_d;
	joy_data_t            rd_word;

	// only bits 5:4 are writable
	assign sel_d = wdata[SEL_LSB +: SEL_WIDTH];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sel_q <= SEL_RESET;
		end else if (wr_stb) begin
			sel_q <= sel_d;
		end
	end

	// active low group selects
	assign p14 = sel_q[SEL_P14];
	assign p15 = sel_q[SEL_P15];

	always_comb begin
		rd_word                                  = BUS_IDLE;
		rd_word[UNUSED_LSB +: $bits(UNUSED_HIGH)] = UNUSED_HIGH;
		rd_word[SEL_LSB +: SEL_WIDTH]            = sel_q;
		rd_word[PAD_LSB +: JOY_LINES]            = pad_sync; // p13..p10, low when pressed
	end

	// bus floats high outside a read
	assign rdata = rd_stb ? rd_word : BUS_IDLE;

endmodule

// ==== logic/bus_bridge.sv ====
`timescale 1ns/1ps

module bus_bridge (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  req,
	input  logic                  we,
	input  joypad_pkg::joy_data_t wdata,
	output logic                  ack,
	output joypad_pkg::joy_data_t rdata,
	output logic                  wr_stb,
	output logic                  rd_stb,
	output joypad_pkg::joy_data_t reg_wdata,
	input  joypad_pkg::joy_data_t reg_rdata
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_ACCESS,
		ST_HOLD
	} state_t;

	state_t state_q;
	state_t state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (req) begin
					state_d = ST_ACCESS;
				end
			end
			ST_ACCESS: begin
				state_d = ST_HOLD; // single strobe cycle
			end
			ST_HOLD: begin
				if (!req) begin
					state_d = ST_IDLE;
				end
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state_q <= ST_IDLE;
			ack     <= 1'b0;
		end else begin
			state_q <= state_d;
			ack     <= (state_d == ST_HOLD); // up after strobe, down once req drops
		end
	end

	// exactly one strobe per access
	assign wr_stb = (state_q == ST_ACCESS) && we;
	assign rd_stb = (state_q == ST_ACCESS) && !we;

	// requester holds wdata stable while req is high
	assign reg_wdata = wdata;

	always_ff @(posedge clk) begin
		if (rd_stb) begin
			rdata <= reg_rdata; // held for the whole ack phase
		end
	end

endmodule

// ==== logic/pin_sync.sv ====
`timescale 1ns/1ps

module pin_sync #(
	parameter int SYNC_STAGES = 2
) (
	input  logic                            clk,
	input  logic                            arst_n,
	input  logic [joypad_pkg::JOY_LINES-1:0] async_in,
	output logic [joypad_pkg::JOY_LINES-1:0] sync_out
);
	import joypad_pkg::*;

	logic [JOY_LINES-1:0] stage_q [SYNC_STAGES];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < SYNC_STAGES; i++) begin
				stage_q[i] <= PAD_IDLE; // lines idle high
			end
		end else begin
			stage_q[0] <= async_in; // first stage may go metastable
			for (int i = 1; i < SYNC_STAGES; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	assign sync_out = stage_q[SYNC_STAGES-1];

endmodule

// ==== logic/joypad_pkg.sv ====
package joypad_pkg;

	// data bus and matrix sizes
	localparam int DATA_WIDTH = 8;
	localparam int JOY_LINES  = 4;
	localparam int SEL_WIDTH  = 2;

	typedef logic [DATA_WIDTH-1:0] joy_data_t;

	// FF00 field positions
	localparam int PAD_LSB    = 0;
	localparam int SEL_LSB    = 4;
	localparam int UNUSED_LSB = 6;

	// bit offsets inside the select field
	localparam int SEL_P14 = 0; // direction keys
	localparam int SEL_P15 = 1; // action buttons

	// reset and idle levels
	localparam logic [SEL_WIDTH-1:0] SEL_RESET   = 2'b11; // nothing selected
	localparam logic [1:0]           UNUSED_HIGH = 2'b11;
	localparam logic [JOY_LINES-1:0] PAD_IDLE    = '1;    // no key pulls a line low
	localparam joy_data_t            BUS_IDLE    = '1;

endpackage
